/* include/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
// number of ways per set
`define ICACHE_WAYS 4

// sets per way, indexed by fetch address bits above the line offset
`define ICACHE_SETS 64

// one line holds four instructions
`define ICACHE_LINE_BITS 128

// fetch address width of the core
`define ICACHE_ADDR_BITS 64

// fixed instruction width
`define ICACHE_INST_BITS 32

`endif

/* rtl/icache_addr_pkg.sv */
`default_nettype none

`include "icache_cfg.svh"

package icache_addr_pkg;

	// byte offset inside a line, address bits 3:0
	localparam int OFFSET_BITS = $clog2(`ICACHE_LINE_BITS / 8);
	// set index just above the offset
	localparam int INDEX_BITS = $clog2(`ICACHE_SETS);
	// whatever is left goes to the tag
	localparam int TAG_BITS = `ICACHE_ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	// instruction slots per line
	localparam int WORDS_PER_LINE = `ICACHE_LINE_BITS / `ICACHE_INST_BITS;
	localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
	// slot select starts above the byte-in-word bits
	localparam int WORD_LSB = $clog2(`ICACHE_INST_BITS / 8);

	typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

	// one bit per way, at most one set
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

	typedef logic [`ICACHE_INST_BITS-1:0] inst_t;
	// slot 0 sits in the low 32 bits
	typedef inst_t [WORDS_PER_LINE-1:0] line_t;

endpackage

`default_nettype wire

/* rtl/icache_ctrl_pkg.sv */
`default_nettype none

package icache_ctrl_pkg;

	// what the data stage does with the current fetch
	typedef enum logic [1:0] {
		// no fetch this cycle
		LK_IDLE = 2'd0,
		// tag matched, read that way
		LK_HIT  = 2'd1,
		// miss, write victim way and pass the memory line through
		LK_FILL = 2'd2,
		// fetch killed by flush
		LK_DROP = 2'd3
	} lookup_action_e;

	// true for actions that return an instruction one cycle later
	function automatic logic lk_has_result(lookup_action_e act);
		return (act == LK_HIT) || (act == LK_FILL);
	endfunction

endpackage

`default_nettype wire

/* rtl/icache_lookup_if.sv */
`default_nettype none

// lookup decision from the tag stage to the data and result stages
interface icache_lookup_if
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
();

	// action for this cycle only, no handshake
	lookup_action_e action;
	// matching way on a hit, victim way on a fill
	way_mask_t way;
	// set of the current fetch
	index_t index;
	// instruction slot of the current fetch
	word_sel_t word;

	modport dec (
		output action, way, index, word
	);

	// data arrays need the set and the way
	modport exe (
		input action, way, index
	);

	// result stage only needs the slot
	modport res (
		input action, word
	);

endinterface

`default_nettype wire

/* rtl/icache_decode.sv */
`default_nettype none

`include "icache_cfg.svh"

module icache_decode
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic fetch_valid,
	input addr_t fetch_addr,
	input logic flush,
	output addr_t mem_addr,
	icache_lookup_if.dec lk
);

	// address fields
	tag_t fetch_tag;
	index_t fetch_index;
	word_sel_t fetch_word;

	// tag store, one entry per way and set
	tag_t tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	// one valid bit per way and set
	logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid_q;

	// one-hot round robin victim
	way_mask_t victim_q;

	way_mask_t way_hit;
	way_mask_t sel_way;
	lookup_action_e action;
	logic fill_en;

	assign fetch_tag = fetch_addr[`ICACHE_ADDR_BITS-1 -: TAG_BITS];
	assign fetch_index = fetch_addr[OFFSET_BITS +: INDEX_BITS];
	assign fetch_word = fetch_addr[WORD_LSB +: WORD_SEL_BITS];

	// memory always sees the line-aligned address
	// it answers in the same cycle
	assign mem_addr = {fetch_addr[`ICACHE_ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// compare against all ways at once
	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			way_hit[w] = valid_q[w][fetch_index] && (tag_mem[w][fetch_index] == fetch_tag);
		end
	end

	// flush wins over hit and miss
	always_comb begin
		if (!fetch_valid) begin
			action = LK_IDLE;
		end else if (flush) begin
			action = LK_DROP;
		end else if (|way_hit) begin
			action = LK_HIT;
		end else begin
			action = LK_FILL;
		end
	end

	assign fill_en = (action == LK_FILL);

	// way for the data stage
	// zero when nothing is read or written
	always_comb begin
		case (action)
			LK_HIT: sel_way = way_hit;
			LK_FILL: sel_way = victim_q;
			default: sel_way = '0;
		endcase
	end

	assign lk.action = action;
	assign lk.way = sel_way;
	assign lk.index = fetch_index;
	assign lk.word = fetch_word;

	// valid bits and victim pointer
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			// start at way 0
			victim_q <= way_mask_t'(1);
		end else if (fill_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_q[w]) begin
					valid_q[w][fetch_index] <= 1'b1;
				end
			end
			// rotate left by one way per fill
			victim_q <= {victim_q[`ICACHE_WAYS-2:0], victim_q[`ICACHE_WAYS-1]};
		end
	end

	// tag write on fill, same edge as the data write
	// so a refetch right after hits
	always_ff @(posedge clk) begin
		if (!rst && fill_en) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_q[w]) begin
					tag_mem[w][fetch_index] <= fetch_tag;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_execute.sv */
`default_nettype none

`include "icache_cfg.svh"

module icache_execute
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input line_t mem_line,
	icache_lookup_if.exe lk,
	output line_t rd_line,
	output line_t fill_line
);

	// raw read port of each way at the current index
	line_t way_dout [`ICACHE_WAYS];
	// selected way before the output register
	line_t hit_line;
	logic fill_en;
	logic read_en;

	// no array write while held in reset
	assign fill_en = !rst && (lk.action == LK_FILL);
	assign read_en = (lk.action == LK_HIT);

	// one data array per way
	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		line_t mem [`ICACHE_SETS];

		// only the victim way takes the memory line
		always_ff @(posedge clk) begin
			if (fill_en && lk.way[w]) begin
				mem[lk.index] <= mem_line;
			end
		end

		assign way_dout[w] = mem[lk.index];
	end

	// one-hot and-or select of the hit way
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (lk.way[w]) begin
				hit_line = hit_line | way_dout[w];
			end
		end
	end

	// registered read, like an sram output
	// holds its value when there is no hit
	always_ff @(posedge clk) begin
		if (read_en) begin
			rd_line <= hit_line;
		end
	end

	// capture the memory line for the bypass path
	// result picks it up one cycle later
	always_ff @(posedge clk) begin
		if (lk.action == LK_FILL) begin
			fill_line <= mem_line;
		end
	end

endmodule

`default_nettype wire

/* rtl/icache_result.sv */
`default_nettype none

module icache_result
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	icache_lookup_if.res lk,
	input line_t rd_line,
	input line_t fill_line,
	output logic inst_valid,
	output inst_t inst,
	output logic hit
);

	// slot of the fetch from last cycle
	word_sel_t word_q;
	// line chosen between array read and bypass
	line_t sel_line;

	// hit or fill returns something, idle and drop do not
	always_ff @(posedge clk) begin
		if (rst) begin
			inst_valid <= 1'b0;
			hit <= 1'b0;
		end else begin
			inst_valid <= lk_has_result(lk.action);
			hit <= (lk.action == LK_HIT);
		end
	end

	// slot for the word extract next cycle
	always_ff @(posedge clk) begin
		word_q <= lk.word;
	end

	// after a miss the memory line is forwarded
	assign sel_line = hit ? rd_line : fill_line;

	// pick the 32-bit slot
	assign inst = sel_line[word_q];

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`default_nettype none

module icache_top
	import icache_addr_pkg::*;
(
	input logic clk,
	input logic rst,
	// fetch request
	input logic fetch_valid,
	input addr_t fetch_addr,
	input logic flush,
	// line-aligned refill port, answered combinationally
	output addr_t mem_addr,
	input line_t mem_line,
	// result one cycle after the fetch
	output logic inst_valid,
	output inst_t inst,
	output logic hit
);

	// data stage to result stage
	line_t rd_line;
	line_t fill_line;

	icache_lookup_if u_lookup_if ();

	// tags, compare, victim and action
	icache_decode u_decode (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.flush(flush),
		.mem_addr(mem_addr),
		.lk(u_lookup_if.dec)
	);

	// data arrays and fill capture
	icache_execute u_execute (
		.clk(clk),
		.rst(rst),
		.mem_line(mem_line),
		.lk(u_lookup_if.exe),
		.rd_line(rd_line),
		.fill_line(fill_line)
	);

	// word extract and output flags
	icache_result u_result (
		.clk(clk),
		.rst(rst),
		.lk(u_lookup_if.res),
		.rd_line(rd_line),
		.fill_line(fill_line),
		.inst_valid(inst_valid),
		.inst(inst),
		.hit(hit)
	);

endmodule

`default_nettype wire

/* test/icache_chk.sv */
`default_nettype none

module icache_chk
	import icache_addr_pkg::*, icache_ctrl_pkg::*;
(
	input logic clk,
	input logic rst,
	input lookup_action_e action,
	input way_mask_t way,
	input logic inst_valid,
	input logic hit
);

	// never more than one way read or written
	assert property (@(posedge clk) disable iff (rst) $onehot0(way))
		else $error("way field has more than one bit set: %b", way);

	// hit and fill both return an instruction next cycle
	assert property (@(posedge clk) disable iff (rst)
		(action == LK_HIT || action == LK_FILL) |=> inst_valid)
		else $error("no inst_valid one cycle after a hit or fill");

	// a flushed fetch returns nothing
	assert property (@(posedge clk) disable iff (rst)
		(action == LK_DROP) |=> !inst_valid)
		else $error("inst_valid set one cycle after a dropped fetch");

	// idle gives no result either
	assert property (@(posedge clk) disable iff (rst)
		(action == LK_IDLE) |=> !inst_valid)
		else $error("inst_valid set one cycle after an idle cycle");

	// hit is a subset of valid results
	assert property (@(posedge clk) disable iff (rst) hit |-> inst_valid)
		else $error("hit set without inst_valid");

endmodule

`default_nettype wire

/* test/tb_icache.sv */
`default_nettype none

`include "icache_cfg.svh"

module tb_icache
	import icache_addr_pkg::*;
();

	// columns per stimulus line and room for lines
	localparam int FIELDS = 6;
	localparam int MAX_LINES = 64;
	localparam int RESET_CYCLES = 10;

	logic clk;
	logic rst;
	logic fetch_valid;
	addr_t fetch_addr;
	logic flush;
	addr_t mem_addr;
	line_t mem_line;
	logic inst_valid;
	logic [`ICACHE_INST_BITS-1:0] inst;
	logic hit;

	// generation byte of the memory model
	logic [7:0] gen;
	logic [63:0] stim_mem [FIELDS*MAX_LINES];
	int errors;
	int hit_count;
	int cycles;
	int cycle_limit;

	icache_top u_icache_top (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_addr(fetch_addr),
		.flush(flush),
		.mem_addr(mem_addr),
		.mem_line(mem_line),
		.inst_valid(inst_valid),
		.inst(inst),
		.hit(hit)
	);

	bind icache_top icache_chk u_chk (
		.clk(clk),
		.rst(rst),
		.action(u_lookup_if.action),
		.way(u_lookup_if.way),
		.inst_valid(inst_valid),
		.hit(hit)
	);

	// each word is the generation over the low 24 bits of its own address
	function automatic line_t memory_line(addr_t base, logic [7:0] g);
		line_t l;
		for (int k = 0; k < 4; k++) begin
			l[k] = {g, base[23:0] + 24'(4 * k)};
		end
		return l;
	endfunction

	// memory answers in the same cycle
	assign mem_line = memory_line(mem_addr, gen);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// run limit, set once the stimulus length is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, fetch results did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_result(input int n, input addr_t addr, input logic exp_valid,
		input logic exp_hit, input logic [31:0] exp_inst);
		addr_t exp_mem_addr;
		// refill port sees the 16-byte line base
		exp_mem_addr = {addr[63:4], 4'h0};
		assert (mem_addr === exp_mem_addr) else begin
			$display("** Error line %0d: mem_addr got %h expected %h", n, mem_addr,
				exp_mem_addr);
			errors++;
		end
		assert (inst_valid === exp_valid) else begin
			$display("** Error line %0d: inst_valid got %h expected %h", n, inst_valid, exp_valid);
			errors++;
		end
		assert (hit === (exp_valid & exp_hit)) else begin
			$display("** Error line %0d: hit got %h expected %h", n, hit, exp_valid & exp_hit);
			errors++;
		end
		// instruction only means something with inst_valid
		if (exp_valid) begin
			assert (inst === exp_inst) else begin
				$display("** Error line %0d: inst got %h expected %h", n, inst, exp_inst);
				errors++;
			end
		end
		if (hit === 1'b1) begin
			hit_count++;
		end
	endtask

	initial begin
		int n_lines;
		int b;
		rst = 1'b1;
		fetch_valid = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		gen = '0;
		errors = 0;
		hit_count = 0;
		cycles = 0;
		cycle_limit = 1000;
		// all ones marks lines the file did not fill
		for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
			stim_mem[i] = '1;
		end
		$readmemh("test/icache_stimulus.txt", stim_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim_mem[FIELDS * n_lines] !== '1) begin
			n_lines++;
		end
		cycle_limit = n_lines + RESET_CYCLES + 20;
		if (n_lines == 0) begin
			$display("no stimulus lines could be read from the stimulus file");
			errors++;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		// drive on one falling edge, check on the next
		for (int i = 0; i < n_lines; i++) begin
			b = FIELDS * i;
			fetch_valid = stim_mem[b][0];
			flush = stim_mem[b + 1][0];
			fetch_addr = stim_mem[b + 2];
			gen = stim_mem[b + 3][7:0];
			@(negedge clk);
			check_result(i + 1, stim_mem[b + 2], stim_mem[b][0] & ~stim_mem[b + 1][0],
				stim_mem[b + 4][0], stim_mem[b + 5][31:0]);
		end
		fetch_valid = 1'b0;
		flush = 1'b0;
		$display("%0d fetches, %0d hits, %0d errors", n_lines, hit_count, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
rtl/icache_addr_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_lookup_if.sv
rtl/icache_decode.sv
rtl/icache_execute.sv
rtl/icache_result.sv
rtl/icache_top.sv
test/icache_chk.sv
test/tb_icache.sv

/* Bender.yml */
package:
  name: icache

sources:
  - include_dirs:
      - include
    files:
      - rtl/icache_addr_pkg.sv
      - rtl/icache_ctrl_pkg.sv
      - rtl/icache_lookup_if.sv
      - rtl/icache_decode.sv
      - rtl/icache_execute.sv
      - rtl/icache_result.sv
      - rtl/icache_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/icache_chk.sv
      - test/tb_icache.sv

/* test/icache_stimulus.txt */
// valid flush addr gen exp_hit exp_inst, all hex
// exp_inst is {gen, addr[23:0]} of the word that was first filled
// cold miss, then refetch and all word offsets of the line
1 0 1000 a1 0 a1001000
1 0 1004 a1 1 a1001004
1 0 1008 a1 1 a1001008
1 0 100c a1 1 a100100c
1 0 1000 a1 1 a1001000
// new generation, cached line keeps old data
1 0 1004 b2 1 a1001004
1 0 2010 b2 0 b2002010
1 0 2018 b2 1 b2002018
// idle, flushed fetch, idle
0 0 0 b2 0 0
1 1 5000 b2 0 0
0 0 0 b2 0 0
// flushed line was not installed
1 0 5008 b2 0 b2005008
1 0 6004 b2 0 b2006004
1 0 5008 b2 1 b2005008
0 0 0 b2 0 0
// five tags in set 2, victim back at way 0
1 0 3020 b2 0 b2003020
1 0 3420 b2 0 b2003420
1 0 3820 b2 0 b2003820
1 0 3c20 b2 0 b2003c20
1 0 4020 b2 0 b2004020
1 0 3424 b2 1 b2003424
1 0 3828 b2 1 b2003828
1 0 3c2c b2 1 b2003c2c
1 0 4020 b2 1 b2004020
// first tag was evicted
1 0 3020 b2 0 b2003020
1 0 5000 c3 1 b2005000
0 0 0 c3 0 0
